/* hw/core_pkg.sv */
package core_pkg;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------
    typedef logic [31:0] wb_adr_t;    // Wishbone byte address
    typedef logic [31:0] wb_dat_t;    // Wishbone and register-bus data
    typedef logic [3:0]  wb_sel_t;    // Byte enables
    typedef logic [3:0]  reg_adr_t;   // Word index inside one slave
    typedef logic [1:0]  slave_id_t;  // Slave select field

    // Slave map on address bits 9:8
    localparam slave_id_t SLV_GLBL = 2'd0;  // Global config block
    localparam slave_id_t SLV_UART = 2'd1;  // UART core
    // IDs 2 and 3 have no slave and end in err

    // ----------------------------------------
    // Register indices
    // ----------------------------------------
    localparam reg_adr_t REG_GLBL_ID      = 4'd0;
    localparam reg_adr_t REG_GLBL_SCRATCH = 4'd1;
    localparam reg_adr_t REG_GLBL_IRQ     = 4'd2;
    localparam reg_adr_t REG_GLBL_RESET   = 4'd3;

    localparam reg_adr_t REG_UART_CTRL    = 4'd0;
    localparam reg_adr_t REG_UART_BAUD    = 4'd1;
    localparam reg_adr_t REG_UART_STATUS  = 4'd2;
    localparam reg_adr_t REG_UART_TXDATA  = 4'd3;
    localparam reg_adr_t REG_UART_RXDATA  = 4'd4;

    // Slave field of a byte address
    function automatic slave_id_t slave_of(wb_adr_t adr);
        return adr[9:8];
    endfunction

    // Word index, dropping the byte lane bits
    function automatic reg_adr_t reg_of(wb_adr_t adr);
        return adr[5:2];
    endfunction

endpackage : core_pkg

/* hw/reg_bus_if.sv */
`timescale 1ns/100ps

// Simple register bus, one cs pulse per access
interface reg_bus_if import core_pkg::*; ();

    logic     cs;     // One-cycle select
    logic     wr;     // 1 write, 0 read
    reg_adr_t addr;   // Word index
    wb_dat_t  wdata;  // Write data
    wb_sel_t  be;     // Byte enables
    wb_dat_t  rdata;  // Read data, valid with ack
    logic     ack;    // Always one cycle after cs

    // Interconnect side
    modport host (
        output cs, wr, addr, wdata, be,
        input  rdata, ack
    );

    // Slave side
    modport device (
        input  cs, wr, addr, wdata, be,
        output rdata, ack
    );

endinterface : reg_bus_if

/* hw/wb_interconnect.sv */
`timescale 1ns/100ps

// Single master Wishbone to two register-bus slaves
// Ack path: stage, cs, slave ack, response (4 flops)
// Err path: stage, decode, response (3 flops)
module wb_interconnect import core_pkg::*; (
    input  logic    wb_clk_i,
    input  logic    rst_i,

    // Wishbone request
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  wb_adr_t wb_adr_i,
    input  logic    wb_we_i,
    input  wb_dat_t wb_dat_i,
    input  wb_sel_t wb_sel_i,

    // Wishbone response
    output wb_dat_t wb_dat_o,
    output logic    wb_ack_o,
    output logic    wb_err_o,

    reg_bus_if.host glbl_bus,
    reg_bus_if.host uart_bus
);

    logic      busy;        // One request in flight
    logic      capture;     // Take a new request this edge
    logic      stg_vld;     // Staging flop holds a fresh request
    slave_id_t stg_slv;     // Staged slave field
    reg_adr_t  stg_reg;     // Staged word index
    logic      stg_we;
    wb_dat_t   stg_dat;
    wb_sel_t   stg_sel;
    logic      glbl_cs_q;   // Decoded selects
    logic      uart_cs_q;
    logic      unmap_q;     // No slave behind this address

    assign capture = wb_cyc_i && wb_stb_i && !busy;

    // ----------------------------------------
    // Cycle 1: request staging
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            busy    <= 1'b0;
            stg_vld <= 1'b0;
        end else begin
            stg_vld <= capture;  // Pulse, busy blocks a repeat
            if (capture)
                busy <= 1'b1;
            else if (wb_ack_o || wb_err_o)
                busy <= 1'b0;    // Master drops stb on seeing the response
        end
    end

    // Payload, only the fields the slaves need
    always_ff @(posedge wb_clk_i) begin
        if (capture) begin
            stg_slv <= slave_of(wb_adr_i);
            stg_reg <= reg_of(wb_adr_i);
            stg_we  <= wb_we_i;
            stg_dat <= wb_dat_i;
            stg_sel <= wb_sel_i;
        end
    end

    // ----------------------------------------
    // Cycle 2: slave decode
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            glbl_cs_q <= 1'b0;
            uart_cs_q <= 1'b0;
            unmap_q   <= 1'b0;
        end else begin
            glbl_cs_q <= stg_vld && (stg_slv == SLV_GLBL);
            uart_cs_q <= stg_vld && (stg_slv == SLV_UART);
            unmap_q   <= stg_vld && (stg_slv != SLV_GLBL) && (stg_slv != SLV_UART);
        end
    end

    // Staged fields held steady until the next capture
    assign glbl_bus.cs    = glbl_cs_q;
    assign glbl_bus.wr    = stg_we;
    assign glbl_bus.addr  = stg_reg;
    assign glbl_bus.wdata = stg_dat;
    assign glbl_bus.be    = stg_sel;

    assign uart_bus.cs    = uart_cs_q;
    assign uart_bus.wr    = stg_we;
    assign uart_bus.addr  = stg_reg;
    assign uart_bus.wdata = stg_dat;
    assign uart_bus.be    = stg_sel;

    // ----------------------------------------
    // Cycle 4: response combine (err at 3)
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            wb_ack_o <= glbl_bus.ack || uart_bus.ack;  // Only one slave selected
            wb_err_o <= unmap_q;                         // Skips the slave stage
        end
    end

    // Read data picked by whichever ack came back
    always_ff @(posedge wb_clk_i) begin
        if (glbl_bus.ack)
            wb_dat_o <= glbl_bus.rdata;
        else if (uart_bus.ack)
            wb_dat_o <= uart_bus.rdata;
    end

endmodule : wb_interconnect

/* hw/glbl_cfg.sv */
`timescale 1ns/100ps

// Global configuration registers
module glbl_cfg import core_pkg::*; #(
    parameter wb_dat_t DEVICE_IDCODE = 32'h0000_0001
) (
    input  logic         wb_clk_i,
    input  logic         rst_i,
    reg_bus_if.device    bus,
    output logic [2:0]   user_irq_o,
    output logic         uart_rst_o
);

    wb_dat_t    scratch;    // Software scratch word
    logic [2:0] irq_q;      // User interrupt lines
    logic       uart_run;   // 0 holds UART in reset
    logic       wr_en;      // Write strobe
    wb_dat_t    rd_mux;     // Read data before the flop

    assign wr_en = bus.cs && bus.wr;

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            scratch  <= '0;
            irq_q    <= '0;
            uart_run <= 1'b0;      // UART starts held in reset
        end else if (wr_en) begin
            case (bus.addr)
                REG_GLBL_SCRATCH: begin
                    for (int i = 0; i < $bits(wb_sel_t); i++) begin
                        if (bus.be[i])
                            scratch[8*i +: 8] <= bus.wdata[8*i +: 8];
                    end
                end
                REG_GLBL_IRQ: begin
                    if (bus.be[0])
                        irq_q <= bus.wdata[2:0];
                end
                REG_GLBL_RESET: begin
                    if (bus.be[0])
                        uart_run <= bus.wdata[0];
                end
                default: ;         // ID and holes ignore writes
            endcase
        end
    end

    // Read decode
    always_comb begin
        rd_mux = '0;
        case (bus.addr)
            REG_GLBL_ID:      rd_mux = DEVICE_IDCODE;
            REG_GLBL_SCRATCH: rd_mux = scratch;
            REG_GLBL_IRQ:     rd_mux = {29'd0, irq_q};
            REG_GLBL_RESET:   rd_mux = {31'd0, uart_run};
            default:          rd_mux = '0;   // Holes read zero
        endcase
    end

    // Ack one cycle after cs, every access
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cs;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (bus.cs)
            bus.rdata <= rd_mux;
    end

    assign user_irq_o = irq_q;
    assign uart_rst_o = !uart_run;  // Released by software

endmodule : glbl_cfg

/* hw/uart_core.sv */
`timescale 1ns/100ps

// 8N1 UART with register port and programmable bit time
module uart_core import core_pkg::*; #(
    parameter logic [7:0] BAUD_DIV_RESET = 8'd16
) (
    input  logic      wb_clk_i,
    input  logic      rst_i,
    input  logic      soft_rst_i,   // From global config
    reg_bus_if.device bus,
    input  logic      uart_rx_i,
    output logic      uart_tx_o
);

    typedef logic [7:0] baud_t;    // Clocks per bit
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    logic       clr;           // Hard or soft reset
    logic [1:0] ctrl_q;        // [0] tx enable, [1] rx enable
    baud_t      baud_q;
    logic       wr_en;
    logic       tx_start;      // Accepted TXDATA write
    logic       rd_rxdata;     // RXDATA read, clears flags
    wb_dat_t    rd_mux;

    tx_state_t  tx_state;
    baud_t      tx_cnt;
    logic [2:0] tx_bit;
    logic [7:0] tx_shift;
    logic       tx_q;

    rx_state_t  rx_state;
    baud_t      rx_cnt;
    logic [2:0] rx_bit;
    logic [7:0] rx_shift;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_frame_err;
    logic       rx_meta, rx_sync, rx_prev;  // Synchronizer and edge detect

    assign clr       = rst_i || soft_rst_i;
    assign wr_en     = bus.cs && bus.wr && bus.be[0];  // Byte-wide registers
    assign tx_start  = wr_en && (bus.addr == REG_UART_TXDATA) && ctrl_q[0]
                       && (tx_state == TX_IDLE);
    assign rd_rxdata = bus.cs && !bus.wr && (bus.addr == REG_UART_RXDATA);

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (clr) begin
            ctrl_q <= '0;
            baud_q <= BAUD_DIV_RESET;
        end else if (wr_en) begin
            if (bus.addr == REG_UART_CTRL)
                ctrl_q <= bus.wdata[1:0];
            if (bus.addr == REG_UART_BAUD)    // Clamp at 4 clocks per bit
                baud_q <= (bus.wdata[7:0] < 8'd4) ? 8'd4 : bus.wdata[7:0];
        end
    end

    always_comb begin
        case (bus.addr)
            REG_UART_CTRL:   rd_mux = {30'd0, ctrl_q};
            REG_UART_BAUD:   rd_mux = {24'd0, baud_q};
            REG_UART_STATUS: rd_mux = {29'd0, rx_frame_err, rx_valid, tx_state != TX_IDLE};
            REG_UART_RXDATA: rd_mux = {24'd0, rx_data};
            default:         rd_mux = '0;   // TXDATA is write only
        endcase
    end

    // Port stays responsive during soft reset
    always_ff @(posedge wb_clk_i) begin
        if (rst_i)
            bus.ack <= 1'b0;
        else
            bus.ack <= bus.cs;
    end

    always_ff @(posedge wb_clk_i) begin
        if (bus.cs)
            bus.rdata <= rd_mux;
    end

    // ----------------------------------------
    // Transmitter
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (clr) begin
            tx_state <= TX_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx_q     <= 1'b1;                    // Line idles high
        end else begin
            case (tx_state)
                TX_IDLE: if (tx_start) begin
                    tx_shift <= bus.wdata[7:0];
                    tx_q     <= 1'b0;            // Start bit
                    tx_cnt   <= baud_q - 8'd1;
                    tx_state <= TX_START;
                end
                TX_START: if (tx_cnt == '0) begin
                    tx_q     <= tx_shift[0];     // LSB first
                    tx_bit   <= '0;
                    tx_cnt   <= baud_q - 8'd1;
                    tx_state <= TX_DATA;
                end else begin
                    tx_cnt <= tx_cnt - 8'd1;
                end
                TX_DATA: if (tx_cnt == '0) begin
                    tx_cnt <= baud_q - 8'd1;
                    if (tx_bit == 3'd7) begin
                        tx_q     <= 1'b1;        // Stop bit
                        tx_state <= TX_STOP;
                    end else begin
                        tx_shift <= tx_shift >> 1;
                        tx_q     <= tx_shift[1];
                        tx_bit   <= tx_bit + 3'd1;
                    end
                end else begin
                    tx_cnt <= tx_cnt - 8'd1;
                end
                TX_STOP: if (tx_cnt == '0)
                    tx_state <= TX_IDLE;
                else
                    tx_cnt <= tx_cnt - 8'd1;
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    assign uart_tx_o = tx_q;

    // ----------------------------------------
    // Receiver
    // ----------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (clr) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx_i;   // Two-flop synchronizer
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (clr) begin
            rx_state     <= RX_IDLE;
            rx_cnt       <= '0;
            rx_bit       <= '0;
            rx_data      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            if (rd_rxdata) begin
                rx_valid     <= 1'b0;
                rx_frame_err <= 1'b0;
            end
            case (rx_state)
                RX_IDLE: if (ctrl_q[1] && rx_prev && !rx_sync) begin
                    rx_cnt   <= {1'b0, baud_q[7:1]} - 8'd1;  // Half bit to mid start
                    rx_state <= RX_START;
                end
                RX_START: if (rx_cnt == '0) begin
                    rx_cnt   <= baud_q - 8'd1;
                    rx_bit   <= '0;
                    rx_state <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch back to idle
                end else begin
                    rx_cnt <= rx_cnt - 8'd1;
                end
                RX_DATA: if (rx_cnt == '0) begin
                    rx_shift <= {rx_sync, rx_shift[7:1]};
                    rx_cnt   <= baud_q - 8'd1;
                    rx_bit   <= rx_bit + 3'd1;
                    if (rx_bit == 3'd7)
                        rx_state <= RX_STOP;
                end else begin
                    rx_cnt <= rx_cnt - 8'd1;
                end
                RX_STOP: if (rx_cnt == '0) begin
                    rx_data      <= rx_shift;
                    rx_valid     <= 1'b1;
                    rx_frame_err <= !rx_sync;   // Stop bit must be high
                    rx_state     <= RX_IDLE;
                end else begin
                    rx_cnt <= rx_cnt - 8'd1;
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

endmodule : uart_core

/* hw/digital_core.sv */
`timescale 1ns/100ps

// System-bus core: Wishbone port, global config and UART
module digital_core import core_pkg::*; #(
    parameter wb_dat_t    DEVICE_IDCODE  = 32'h0D1C_0001,
    parameter logic [7:0] BAUD_DIV_RESET = 8'd16
) (
    input  logic       wb_clk_i,    // System clock
    input  logic       rst_i,       // Sync reset, active high

    // External Wishbone master
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  wb_adr_t    wb_adr_i,
    input  logic       wb_we_i,
    input  wb_dat_t    wb_dat_i,
    input  wb_sel_t    wb_sel_i,
    output wb_dat_t    wb_dat_o,
    output logic       wb_ack_o,
    output logic       wb_err_o,

    // UART lines
    input  logic       uart_rx_i,
    output logic       uart_tx_o,

    output logic [2:0] user_irq_o
);

    logic uart_soft_rst;  // Held until software sets uart_run

    reg_bus_if glbl_bus ();
    reg_bus_if uart_bus ();

    // ----------------------------------------
    // Interconnect
    // ----------------------------------------
    wb_interconnect u_intercon (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_adr_i (wb_adr_i),
        .wb_we_i  (wb_we_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o),
        .glbl_bus (glbl_bus.host),
        .uart_bus (uart_bus.host)
    );

    // Slaves side by side
    glbl_cfg #(
        .DEVICE_IDCODE (DEVICE_IDCODE)
    ) u_glbl_cfg (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .bus        (glbl_bus.device),
        .user_irq_o (user_irq_o),
        .uart_rst_o (uart_soft_rst)
    );

    uart_core #(
        .BAUD_DIV_RESET (BAUD_DIV_RESET)
    ) u_uart_core (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .soft_rst_i (uart_soft_rst),
        .bus        (uart_bus.device),
        .uart_rx_i  (uart_rx_i),
        .uart_tx_o  (uart_tx_o)
    );

endmodule : digital_core

/* sim/wb_monitor.sv */
`timescale 1ns/100ps

// Watches the Wishbone response and compares it with the entry's expected values
module wb_monitor import core_pkg::*; (
    input  logic       wb_clk_i,
    input  logic       rst_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  wb_dat_t    wb_dat_i,     // DUT read data
    input  logic       wb_ack_i,
    input  logic       wb_err_i,
    input  logic [2:0] user_irq_i,
    input  int         test_id_i,
    input  wb_dat_t    exp_dat_i,
    input  wb_dat_t    exp_mask_i,
    input  logic       exp_err_i,
    input  logic       poll_i,
    output logic       match_o,      // Last response matched under the mask
    output int         n_tests_o,
    output int         n_fails_o
);

    localparam int ACK_EDGES = 4;   // Stage, cs, slave ack, response
    localparam int ERR_EDGES = 3;

    logic    busy;                  // Request seen, response pending
    logic    bad;                   // Current test hit a failed check
    logic    hit;
    int      edges;
    int      cur_id;
    int      n_done, n_bad;
    logic    cur_we, cur_err, cur_poll;
    wb_dat_t cur_exp, cur_mask;

    always @(posedge wb_clk_i) begin
        if (rst_i) begin
            busy = 1'b0;
            bad = 1'b0;
            n_done = 0;
            n_bad = 0;
            match_o <= 1'b0;
        end else if (!busy) begin
            if (wb_ack_i || wb_err_i) begin
                $display("Response seen with no request in flight");
                n_bad++;
            end
            if (wb_cyc_i && wb_stb_i) begin   // First edge of a request
                busy = 1'b1;
                edges = 0;
                cur_id = test_id_i;
                cur_we = wb_we_i;
                cur_exp = exp_dat_i;
                cur_mask = exp_mask_i;
                cur_err = exp_err_i;
                cur_poll = poll_i;
            end
        end else begin
            edges++;
            hit = 1'b1;
            if (wb_ack_i && wb_err_i) begin
                $display("Test %0d: ack and err high in the same cycle", cur_id);
                bad = 1'b1;
            end else if (cur_err && wb_ack_i) begin
                $display("Test %0d: ack on an unmapped address, err expected", cur_id);
                bad = 1'b1;
            end else if (wb_err_i && !cur_err) begin
                $display("Test %0d: err on a mapped address", cur_id);
                bad = 1'b1;
            end else if (wb_err_i && edges != ERR_EDGES) begin
                $display("Test %0d: err after %0d edges, expected %0d", cur_id, edges, ERR_EDGES);
                bad = 1'b1;
            end else if (wb_ack_i) begin
                if (edges != ACK_EDGES) begin
                    $display("Test %0d: ack after %0d edges, expected %0d", cur_id, edges,
                             ACK_EDGES);
                    bad = 1'b1;
                end
                if (!cur_we) begin
                    hit = ((wb_dat_i ^ cur_exp) & cur_mask) == '0;
                    if (!hit && !cur_poll) begin   // Poll misses just retry
                        $display("CHECK FAILED test %0d wb_dat_o expected %h got %h mask %h",
                                 cur_id, cur_exp, wb_dat_i, cur_mask);
                        bad = 1'b1;
                    end
                end else if (cur_mask != '0) begin // IRQ write, check the port
                    hit = (({29'd0, user_irq_i} ^ cur_exp) & cur_mask) == '0;
                    if (!hit) begin
                        $display("CHECK FAILED test %0d user_irq_o expected %h got %h",
                                 cur_id, cur_exp[2:0], user_irq_i);
                        bad = 1'b1;
                    end
                end
            end
            if (wb_ack_i || wb_err_i) begin
                busy = 1'b0;
                match_o <= hit;
                if (!cur_poll || hit) begin        // Test finished
                    n_done++;
                    if (bad)
                        n_bad++;
                    $display("Test %0d: %s", cur_id, bad ? "error" : "ok");
                    bad = 1'b0;
                end
            end
        end
        n_tests_o <= n_done;
        n_fails_o <= n_bad;
    end

endmodule : wb_monitor

/* sim/tb_digital_core.sv */
`timescale 1ns/100ps

// Table-driven Wishbone master for digital_core with the UART looped back
module tb_digital_core import core_pkg::*; ();

    localparam int      CLK_NS      = 8;
    localparam wb_dat_t IDCODE      = 32'h5EC0_17D1;
    localparam int      N_BYTES     = 3;                   // Loopback bytes
    localparam int      N_ENTRIES   = 19 + 4 * N_BYTES;
    localparam int      FRAME_CLKS  = 10 * 16;             // Slowest frame at reset BAUD
    localparam int      ENTRY_CLKS  = FRAME_CLKS + 100;    // Worst poll plus margin
    localparam int      POLL_LIMIT  = 40;                  // Status reads per poll entry
    localparam int      WATCHDOG_NS = (N_ENTRIES * ENTRY_CLKS + 20) * CLK_NS;

    typedef struct {
        logic    we;
        wb_adr_t adr;
        wb_dat_t wdat;
        wb_sel_t sel;
        wb_dat_t exp_dat;
        wb_dat_t mask;      // Read data mask or user_irq_o mask on writes
        logic    exp_err;
        logic    poll;      // Repeat until masked data matches
    } entry_t;

    logic       clk;
    logic       rst;
    logic       cyc, stb, we;
    wb_adr_t    adr;
    wb_dat_t    dat_w, dat_r;
    wb_sel_t    sel;
    logic       ack, err;
    logic [2:0] irq;
    wire        uart_line;   // tx fed straight back to rx

    // Expected values handed to the monitor
    int         test_id;
    wb_dat_t    exp_dat, exp_mask;
    logic       exp_err, exp_poll;
    logic       match;
    int         n_tests, n_fails;

    entry_t      tests [N_ENTRIES];
    int          n_built;
    logic [31:0] rng;
    int          poll_fails;   // Poll entries that ran out of tries

    always #(CLK_NS / 2) clk = ~clk;

    digital_core #(
        .DEVICE_IDCODE  (IDCODE),
        .BAUD_DIV_RESET (8'd16)
    ) UUT (
        .wb_clk_i (clk),      .rst_i    (rst),
        .wb_cyc_i (cyc),      .wb_stb_i (stb),
        .wb_adr_i (adr),      .wb_we_i  (we),
        .wb_dat_i (dat_w),    .wb_sel_i (sel),
        .wb_dat_o (dat_r),    .wb_ack_o (ack),
        .wb_err_o (err),
        .uart_rx_i (uart_line),
        .uart_tx_o (uart_line),
        .user_irq_o (irq)
    );

    wb_monitor u_monitor (
        .wb_clk_i (clk),       .rst_i    (rst),
        .wb_cyc_i (cyc),       .wb_stb_i (stb),
        .wb_we_i  (we),        .wb_dat_i (dat_r),
        .wb_ack_i (ack),       .wb_err_i (err),
        .user_irq_i (irq),     .test_id_i (test_id),
        .exp_dat_i (exp_dat),  .exp_mask_i (exp_mask),
        .exp_err_i (exp_err),  .poll_i   (exp_poll),
        .match_o  (match),
        .n_tests_o (n_tests),  .n_fails_o (n_fails)
    );

    // ----------------------------------------
    // Table helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Slave field at 9:8 and word index at 5:2
    function automatic wb_adr_t reg_addr(input slave_id_t slv, input reg_adr_t idx);
        return {22'd0, slv, 2'b00, idx, 2'b00};
    endfunction

    // Register after a write with byte enables
    function automatic wb_dat_t merge_bytes(input wb_dat_t old, input wb_dat_t nw,
                                            input wb_sel_t be);
        wb_dat_t m;
        for (int b = 0; b < 4; b++)
            m[8*b +: 8] = be[b] ? nw[8*b +: 8] : old[8*b +: 8];
        return m;
    endfunction

    task automatic append_entry(input logic w, input wb_adr_t a, input wb_dat_t d,
                                input wb_sel_t be, input wb_dat_t e, input wb_dat_t m,
                                input logic er, input logic p);
        tests[n_built] = '{w, a, d, be, e, m, er, p};
        n_built++;
    endtask

    task automatic read_check(input wb_adr_t a, input wb_dat_t e, input wb_dat_t m,
                              input logic p);
        append_entry(1'b0, a, '0, 4'hF, e, m, 1'b0, p);
    endtask

    task automatic write_reg(input wb_adr_t a, input wb_dat_t d, input wb_sel_t be,
                             input wb_dat_t irq_exp, input wb_dat_t irq_mask);
        append_entry(1'b1, a, d, be, irq_exp, irq_mask, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        wb_dat_t scratch_model;
        wb_dat_t rx_byte;
        read_check(reg_addr(SLV_GLBL, REG_GLBL_ID), IDCODE, '1, 1'b0);
        write_reg(reg_addr(SLV_GLBL, REG_GLBL_ID), 32'hFFFF_FFFF, 4'hF, '0, '0);
        read_check(reg_addr(SLV_GLBL, REG_GLBL_ID), IDCODE, '1, 1'b0);   // Write ignored
        rng = xorshift(rng);
        scratch_model = rng;
        write_reg(reg_addr(SLV_GLBL, REG_GLBL_SCRATCH), rng, 4'hF, '0, '0);
        read_check(reg_addr(SLV_GLBL, REG_GLBL_SCRATCH), scratch_model, '1, 1'b0);
        rng = xorshift(rng);
        scratch_model = merge_bytes(scratch_model, rng, 4'b0101);
        write_reg(reg_addr(SLV_GLBL, REG_GLBL_SCRATCH), rng, 4'b0101, '0, '0);
        read_check(reg_addr(SLV_GLBL, REG_GLBL_SCRATCH), scratch_model, '1, 1'b0);
        rng = xorshift(rng);
        scratch_model = merge_bytes(scratch_model, rng, 4'b1010);
        write_reg(reg_addr(SLV_GLBL, REG_GLBL_SCRATCH), rng, 4'b1010, '0, '0);
        read_check(reg_addr(SLV_GLBL, REG_GLBL_SCRATCH), scratch_model, '1, 1'b0);
        rng = xorshift(rng);   // IRQ lines checked at the port on ack
        write_reg(reg_addr(SLV_GLBL, REG_GLBL_IRQ), rng, 4'h1, {29'd0, rng[2:0]}, 32'h7);
        read_check(reg_addr(SLV_GLBL, REG_GLBL_IRQ), {29'd0, rng[2:0]}, '1, 1'b0);
        append_entry(1'b0, reg_addr(2'd2, 4'd0), '0, 4'hF, '0, '0, 1'b1, 1'b0);  // Unmapped
        append_entry(1'b1, reg_addr(2'd3, 4'd1), '0, 4'hF, '0, '0, 1'b1, 1'b0);
        // UART still in soft reset
        write_reg(reg_addr(SLV_UART, REG_UART_CTRL), 32'h3, 4'h1, '0, '0);  // Must not stick
        write_reg(reg_addr(SLV_UART, REG_UART_TXDATA), 32'h55, 4'h1, '0, '0);
        read_check(reg_addr(SLV_UART, REG_UART_STATUS), '0, '1, 1'b0);
        write_reg(reg_addr(SLV_GLBL, REG_GLBL_RESET), 32'h1, 4'h1, '0, '0);
        write_reg(reg_addr(SLV_UART, REG_UART_BAUD), 32'h8, 4'h1, '0, '0);
        write_reg(reg_addr(SLV_UART, REG_UART_CTRL), 32'h3, 4'h1, '0, '0);
        for (int k = 0; k < N_BYTES; k++) begin
            rng = xorshift(rng);
            rx_byte = {24'd0, rng[7:0]};
            write_reg(reg_addr(SLV_UART, REG_UART_TXDATA), rx_byte, 4'h1, '0, '0);
            read_check(reg_addr(SLV_UART, REG_UART_STATUS), 32'h2, 32'h2, 1'b1);
            read_check(reg_addr(SLV_UART, REG_UART_RXDATA), rx_byte, '1, 1'b0);
            read_check(reg_addr(SLV_UART, REG_UART_STATUS), '0, 32'h6, 1'b0);  // Flags cleared
        end
    endtask

    // ----------------------------------------
    // Wishbone master
    // ----------------------------------------
    task automatic run_entry(input int idx);
        int   tries;
        logic done;
        tries = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);            // Also the idle cycle between requests
            cyc      <= 1'b1;
            stb      <= 1'b1;
            adr      <= tests[idx].adr;
            we       <= tests[idx].we;
            dat_w    <= tests[idx].wdat;
            sel      <= tests[idx].sel;
            test_id  <= idx;
            exp_dat  <= tests[idx].exp_dat;
            exp_mask <= tests[idx].mask;
            exp_err  <= tests[idx].exp_err;
            exp_poll <= tests[idx].poll;
            do
                @(posedge clk);
            while (!(ack || err));     // Watchdog covers a missing response
            cyc <= 1'b0;
            stb <= 1'b0;
            @(posedge clk);            // Monitor verdict settled
            tries++;
            if (!tests[idx].poll || match) begin
                done = 1'b1;
            end else if (tries >= POLL_LIMIT) begin
                $display("Test %0d: no received byte after %0d status reads", idx, tries);
                poll_fails++;
                done = 1'b1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        sel = '0;
        test_id = 0;
        exp_dat = '0;
        exp_mask = '0;
        exp_err = 1'b0;
        exp_poll = 1'b0;
        n_built = 0;
        poll_fails = 0;
        rng = 32'hd8c5_de6e;
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
            run_entry(i);
        repeat (2) @(posedge clk);
        $display("Tests run: %0d, failed: %0d", n_tests + poll_fails, n_fails + poll_fails);
        if (n_fails == 0 && poll_fails == 0 && n_tests == N_ENTRIES)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_digital_core

/* project.f */
hw/core_pkg.sv
hw/reg_bus_if.sv
hw/wb_interconnect.sv
hw/glbl_cfg.sv
hw/uart_core.sv
hw/digital_core.sv
sim/wb_monitor.sv
sim/tb_digital_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_digital_core -f project.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1
